// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

  //////////////////////////////////////////////////
  // Word and field types
  //////////////////////////////////////////////////

  // Base 32-bit instruction word
  typedef logic [31:0] instr_t;

  typedef logic [4:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;
  typedef logic [1:0] quad_t;

  // Machine width mode as driven on st_xlen
  // Codes not listed here behave as RV64
  typedef enum logic [1:0] {
    RV32 = 2'b01,
    RV64 = 2'b10
  } xlen_mode_t;

  //////////////////////////////////////////////////
  // Field positions
  //////////////////////////////////////////////////

  localparam int F7_HI  = 31;
  localparam int F7_LO  = 25;
  localparam int F3_HI  = 14;
  localparam int F3_LO  = 12;
  localparam int OPC_HI = 6;
  localparam int OPC_LO = 2;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Low two bits of every 32-bit instruction
  localparam quad_t   QUAD_32    = 2'b11;

  localparam opcode_t OPC_OP     = 5'b01100;
  localparam opcode_t OPC_OP32   = 5'b01110;

  // M extension marker
  localparam funct7_t F7_MULDIV  = 7'b0000001;

  localparam funct3_t F3_MUL     = 3'b000;
  localparam funct3_t F3_MULH    = 3'b001;
  localparam funct3_t F3_MULHSU  = 3'b010;
  localparam funct3_t F3_MULHU   = 3'b011;

endpackage

// ==== verilog/mul_cfg_pkg.sv ====
package mul_cfg_pkg;

  //////////////////////////////////////////////////
  // Sizes and latency
  //////////////////////////////////////////////////

  localparam int XLEN        = 64;
  localparam int DXLEN       = 2 * XLEN;

  // Cycles from acceptance to result, legal range 1 to 3
  localparam int MUL_LATENCY = 2;
  localparam int CNT_W       = $clog2(MUL_LATENCY + 1);

  typedef logic [XLEN-1:0]  xword_t;
  typedef logic [DXLEN-1:0] dword_t;
  typedef logic [CNT_W-1:0] lat_cnt_t;

  //////////////////////////////////////////////////
  // Internal enums
  //////////////////////////////////////////////////

  // Operation class shared by prep and datapath
  typedef enum logic [2:0] {
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW
  } mul_op_t;

  typedef enum logic {SEQ_IDLE, SEQ_WAIT} seq_state_t;

endpackage

// ==== verilog/mul_decode.sv ====
module mul_decode (
  input  rv_isa_pkg::instr_t   id_instr,
  input  logic [1:0]           st_xlen,
  output logic                 is_mul,
  output mul_cfg_pkg::mul_op_t mul_op
);
  import rv_isa_pkg::*;
  import mul_cfg_pkg::*;

  funct7_t    funct7;
  funct3_t    funct3;
  opcode_t    opcode;
  quad_t      quad;
  xlen_mode_t xlen_mode;
  logic       m_ext;

  //////////////////////////////////////////////////
  // Field split
  //////////////////////////////////////////////////

  assign funct7    = id_instr[F7_HI:F7_LO];
  assign funct3    = id_instr[F3_HI:F3_LO];
  assign opcode    = id_instr[OPC_HI:OPC_LO];
  assign quad      = id_instr[1:0];
  assign xlen_mode = xlen_mode_t'(st_xlen);

  // Full-size M-extension word
  assign m_ext = (quad == QUAD_32) && (funct7 == F7_MULDIV);

  //////////////////////////////////////////////////
  // Classify
  //////////////////////////////////////////////////

  always_comb begin
    is_mul = 1'b0;
    mul_op = OP_MUL;
    if (m_ext && opcode == OPC_OP) begin
      // funct3 4 to 7 are divides, left to the divider
      case (funct3)
        F3_MUL:    begin is_mul = 1'b1; mul_op = OP_MUL;    end
        F3_MULH:   begin is_mul = 1'b1; mul_op = OP_MULH;   end
        F3_MULHSU: begin is_mul = 1'b1; mul_op = OP_MULHSU; end
        F3_MULHU:  begin is_mul = 1'b1; mul_op = OP_MULHU;  end
        default:   is_mul = 1'b0;
      endcase
    end else if (m_ext && opcode == OPC_OP32 && funct3 == F3_MUL) begin
      // Word multiply exists only in 64-bit mode
      is_mul = (xlen_mode != RV32);
      mul_op = OP_MULW;
    end
  end

endmodule

// ==== verilog/mul_operand_prep.sv ====
module mul_operand_prep (
  input  mul_cfg_pkg::xword_t  op_a,
  input  mul_cfg_pkg::xword_t  op_b,
  input  mul_cfg_pkg::mul_op_t mul_op,
  output mul_cfg_pkg::xword_t  mult_a,
  output mul_cfg_pkg::xword_t  mult_b,
  output logic                 mult_neg
);
  import mul_cfg_pkg::*;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Widen a 32-bit value by its sign
  function automatic xword_t sext32(input logic [31:0] w);
    sext32 = {{(XLEN-32){w[31]}}, w};
  endfunction

  // Magnitude of a two's complement word
  function automatic xword_t abs_w(input xword_t v);
    abs_w = v[XLEN-1] ? (~v + xword_t'(1)) : v;
  endfunction

  xword_t a_w;
  xword_t b_w;

  // Word forms see only the low halves
  assign a_w = sext32(op_a[31:0]);
  assign b_w = sext32(op_b[31:0]);

  //////////////////////////////////////////////////
  // Unsigned operands
  //////////////////////////////////////////////////

  always_comb begin
    case (mul_op)
      OP_MULW: begin
        mult_a = abs_w(a_w);
        mult_b = abs_w(b_w);
      end
      OP_MULHU: begin
        mult_a = op_a;
        mult_b = op_b;
      end
      OP_MULHSU: begin
        // B is unsigned here
        mult_a = abs_w(op_a);
        mult_b = op_b;
      end
      default: begin
        mult_a = abs_w(op_a);
        mult_b = abs_w(op_b);
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Result sign
  //////////////////////////////////////////////////

  always_comb begin
    case (mul_op)
      OP_MUL, OP_MULH: mult_neg = op_a[XLEN-1] ^ op_b[XLEN-1];
      OP_MULHSU:       mult_neg = op_a[XLEN-1];
      OP_MULW:         mult_neg = op_a[31] ^ op_b[31];
      default:         mult_neg = 1'b0;
    endcase
  end

endmodule

// ==== verilog/mul_datapath.sv ====
module mul_datapath (
  input  logic                 clk,
  input  logic                 issue,
  input  mul_cfg_pkg::xword_t  mult_a,
  input  mul_cfg_pkg::xword_t  mult_b,
  input  logic                 mult_neg,
  input  mul_cfg_pkg::mul_op_t mul_op,
  output mul_cfg_pkg::xword_t  mul_r
);
  import mul_cfg_pkg::*;

  xword_t  a_q;
  xword_t  b_q;
  logic    neg_q;
  mul_op_t op_q;

  dword_t  prod;
  dword_t  prod_st;
  dword_t  corr;
  dword_t  corr_st;

  initial begin
    assert (MUL_LATENCY >= 1 && MUL_LATENCY <= 3)
      else $fatal(1, "mul_datapath: MUL_LATENCY %0d out of range 1..3", MUL_LATENCY);
  end

  //////////////////////////////////////////////////
  // Input registers
  //////////////////////////////////////////////////

  // Held until the next issue, which comes after the result
  always_ff @(posedge clk) begin
    if (issue) begin
      a_q   <= mult_a;
      b_q   <= mult_b;
      neg_q <= mult_neg;
      op_q  <= mul_op;
    end
  end

  //////////////////////////////////////////////////
  // Multiply and sign fix
  //////////////////////////////////////////////////

  // One unsigned array for every form
  assign prod = dword_t'(a_q) * dword_t'(b_q);

  // Two's complement of the full product
  assign corr = neg_q ? (~prod_st + dword_t'(1)) : prod_st;

  generate
    if (MUL_LATENCY >= 2) begin : g_prod_reg
      always_ff @(posedge clk) begin
        prod_st <= prod;
      end
    end else begin : g_prod_comb
      assign prod_st = prod;
    end

    if (MUL_LATENCY == 3) begin : g_corr_reg
      always_ff @(posedge clk) begin
        corr_st <= corr;
      end
    end else begin : g_corr_comb
      assign corr_st = corr;
    end
  endgenerate

  //////////////////////////////////////////////////
  // Result formatting
  //////////////////////////////////////////////////

  // Free running, sampled by writeback on the bubble-low cycle
  always_ff @(posedge clk) begin
    case (op_q)
      OP_MUL:  mul_r <= corr_st[XLEN-1:0];
      OP_MULW: mul_r <= {{(XLEN-32){corr_st[31]}}, corr_st[31:0]};
      default: mul_r <= corr_st[DXLEN-1:XLEN];
    endcase
  end

  // Sign flag from prep must be resolved for every accepted op
  a_neg_known: assert property (@(posedge clk) issue |=> !$isunknown(neg_q))
    else $error("mul_datapath: negate flag unknown after issue");

endmodule

// ==== verilog/mul_sequencer.sv ====
module mul_sequencer (
  input  logic clk,
  input  logic rstn,
  input  logic ex_stall,
  input  logic id_bubble,
  input  logic is_mul,
  output logic issue,
  output logic mul_stall,
  output logic mul_bubble
);
  import mul_cfg_pkg::*;

  seq_state_t state;
  lat_cnt_t   cnt;

  initial begin
    assert (MUL_LATENCY >= 1 && MUL_LATENCY <= 3)
      else $fatal(1, "mul_sequencer: MUL_LATENCY %0d out of range 1..3", MUL_LATENCY);
  end

  //////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////

  // ex_stall only matters while idle
  assign issue = (state == SEQ_IDLE) && !ex_stall && !id_bubble && is_mul;

  //////////////////////////////////////////////////
  // FSM and latency counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= SEQ_IDLE;
      cnt        <= '0;
      mul_stall  <= 1'b0;
      mul_bubble <= 1'b1;
    end else begin
      // Result slot is a single cycle
      mul_bubble <= 1'b1;
      case (state)
        SEQ_IDLE: begin
          if (issue) begin
            state     <= SEQ_WAIT;
            cnt       <= lat_cnt_t'(MUL_LATENCY - 1);
            mul_stall <= 1'b1;
          end
        end
        SEQ_WAIT: begin
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else begin
            // Release decode and hand the result to writeback
            state      <= SEQ_IDLE;
            mul_stall  <= 1'b0;
            mul_bubble <= 1'b0;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////

  a_no_result_in_stall: assert property (@(posedge clk) disable iff (!rstn)
    mul_stall |-> mul_bubble)
    else $error("mul_sequencer: result slot while stalled");

  // No second issue while the latency runs
  a_no_issue_busy: assert property (@(posedge clk) disable iff (!rstn)
    issue |=> !issue [*MUL_LATENCY])
    else $error("mul_sequencer: issue while a multiply is in flight");

  // Stall covers the latency exactly, then drops
  a_stall_len: assert property (@(posedge clk) disable iff (!rstn)
    $rose(mul_stall) |-> mul_stall [*MUL_LATENCY] ##1 !mul_stall)
    else $error("mul_sequencer: stall length differs from latency");

endmodule

// ==== verilog/mul_unit_top.sv ====
module mul_unit_top (
  input  logic                clk,
  input  logic                rstn,
  input  logic                ex_stall,
  input  logic                id_bubble,
  input  rv_isa_pkg::instr_t  id_instr,
  input  mul_cfg_pkg::xword_t op_a,
  input  mul_cfg_pkg::xword_t op_b,
  input  logic [1:0]          st_xlen,
  output logic                mul_stall,
  output logic                mul_bubble,
  output mul_cfg_pkg::xword_t mul_r
);
  import mul_cfg_pkg::*;

  //////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////

  logic    is_mul;
  mul_op_t mul_op;
  logic    issue;

  // Prep to datapath
  xword_t  mult_a;
  xword_t  mult_b;
  logic    mult_neg;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  // Only place that looks at instruction bits
  mul_decode u_decode (
    .id_instr (id_instr),
    .st_xlen  (st_xlen),
    .is_mul   (is_mul),
    .mul_op   (mul_op)
  );

  mul_operand_prep u_prep (
    .op_a     (op_a),
    .op_b     (op_b),
    .mul_op   (mul_op),
    .mult_a   (mult_a),
    .mult_b   (mult_b),
    .mult_neg (mult_neg)
  );

  mul_datapath u_datapath (
    .clk      (clk),
    .issue    (issue),
    .mult_a   (mult_a),
    .mult_b   (mult_b),
    .mult_neg (mult_neg),
    .mul_op   (mul_op),
    .mul_r    (mul_r)
  );

  // Handshake with decode and writeback
  mul_sequencer u_sequencer (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_bubble  (id_bubble),
    .is_mul     (is_mul),
    .issue      (issue),
    .mul_stall  (mul_stall),
    .mul_bubble (mul_bubble)
  );

endmodule

// ==== tb/mul_checker.sv ====
module mul_checker (
  input logic                clk,
  input logic                rstn,
  input logic                ex_stall,
  input logic                id_bubble,
  input rv_isa_pkg::instr_t  id_instr,
  input mul_cfg_pkg::xword_t op_a,
  input mul_cfg_pkg::xword_t op_b,
  input logic [1:0]          st_xlen,
  input logic                mul_stall,
  input logic                mul_bubble,
  input mul_cfg_pkg::xword_t mul_r,
  input logic                drain_done
);
  import rv_isa_pkg::*;
  import mul_cfg_pkg::*;

  // Expected results, one per accepted multiply
  xword_t     exp_r [8];
  logic [2:0] wr_ptr = '0;
  logic [2:0] rd_ptr = '0;

  int      acc_count    = 0;
  int      res_count    = 0;
  int      seen_acc     = 0;
  int      value_errors = 0;
  int      proto_errors = 0;
  int      end_errors   = 0;
  // 0 idle, 1..MUL_LATENCY stalled, MUL_LATENCY+1 result cycle
  int      phase        = 0;
  logic    armed        = 1'b0;
  logic    final_done   = 1'b0;
  logic    is_acc;
  logic    due;
  mul_op_t acc_op;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Own reading of the encoding, bit positions from the ISA manual
  function automatic logic classify(input instr_t w, input logic [1:0] xl,
                                    output mul_op_t op);
    logic m;
    m        = (w[1:0] == 2'b11) && (w[31:25] == F7_MULDIV);
    op       = OP_MUL;
    classify = 1'b0;
    if (m && w[6:2] == OPC_OP && !w[14]) begin
      classify = 1'b1;
      case (w[13:12])
        2'b00:   op = OP_MUL;
        2'b01:   op = OP_MULH;
        2'b10:   op = OP_MULHSU;
        default: op = OP_MULHU;
      endcase
    end else if (m && w[6:2] == OPC_OP32 && w[14:12] == F3_MUL) begin
      op       = OP_MULW;
      // RV32 code is 2'b01
      classify = (xl != 2'b01);
    end
  endfunction

  // Extend, multiply at full width, pick the slice
  function automatic xword_t ref_result(input mul_op_t op, input xword_t a, input xword_t b);
    dword_t      p;
    logic [31:0] pw;
    pw = a[31:0] * b[31:0];
    case (op)
      OP_MULH:   p = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
      OP_MULHSU: p = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
      default:   p = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    endcase
    case (op)
      OP_MUL:  ref_result = p[XLEN-1:0];
      OP_MULW: ref_result = {{(XLEN-32){pw[31]}}, pw};
      default: ref_result = p[DXLEN-1:XLEN];
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Acceptance, inputs stable at the rising edge
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    armed  = rstn;
    is_acc = classify(id_instr, st_xlen, acc_op);
    if (rstn && phase == 0 && !ex_stall && !id_bubble && is_acc) begin
      exp_r[wr_ptr] = ref_result(acc_op, op_a, op_b);
      wr_ptr        = wr_ptr + 3'd1;
      acc_count     = acc_count + 1;
    end
    // End of run bookkeeping
    if (drain_done && !final_done) begin
      final_done = 1'b1;
      if (acc_count != res_count) begin
        $display("Accepted %0d multiplies but saw %0d results", acc_count, res_count);
        end_errors = end_errors + 1;
      end
      if (res_count == 0) begin
        $display("No result was ever checked");
        end_errors = end_errors + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Output checks, outputs stable at the falling edge
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (armed) begin
      if (acc_count != seen_acc) begin
        seen_acc = acc_count;
        phase    = 1;
      end
      due = (phase == MUL_LATENCY + 1);
      // Result slot
      if (!mul_bubble) begin
        if (!due) begin
          $display("Result cycle at %0t outside the expected slot", $time);
          proto_errors = proto_errors + 1;
        end
        if (res_count >= acc_count) begin
          $display("Result at %0t with no accepted multiply", $time);
          proto_errors = proto_errors + 1;
        end else begin
          if (mul_r !== exp_r[rd_ptr]) begin
            $display("ERROR mul_r at %0t: expected 0x%016h got 0x%016h",
                     $time, exp_r[rd_ptr], mul_r);
            value_errors = value_errors + 1;
          end
          rd_ptr    = rd_ptr + 3'd1;
          res_count = res_count + 1;
        end
      end else if (due) begin
        $display("No result cycle at %0t after the latency ran out", $time);
        proto_errors = proto_errors + 1;
      end
      // Stall window
      if (phase >= 1 && phase <= MUL_LATENCY) begin
        if (!mul_stall) begin
          $display("mul_stall low at %0t before the latency ran out", $time);
          proto_errors = proto_errors + 1;
        end
        phase = phase + 1;
      end else begin
        if (mul_stall) begin
          $display("mul_stall high at %0t with nothing in flight", $time);
          proto_errors = proto_errors + 1;
        end
        phase = 0;
      end
    end
  end

endmodule

// ==== tb/tb_mul_unit.sv ====
module tb_mul_unit;
  import rv_isa_pkg::*;
  import mul_cfg_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 8;
  localparam int NUM_SLOTS  = 400;
  // Worst slot is two held cycles, the issue cycle and the latency
  localparam int WATCHDOG_CYCLES = NUM_SLOTS * (MUL_LATENCY + 3) + RST_CYCLES + 100;

  logic   clk;
  logic   rstn;
  logic   ex_stall;
  logic   id_bubble;
  instr_t id_instr;
  xword_t op_a;
  xword_t op_b;
  logic [1:0] st_xlen;
  logic   mul_stall;
  logic   mul_bubble;
  xword_t mul_r;
  logic   drain_done;
  int     seed;
  int     errors;
  int     n;

  //////////////////////////////////////////////////
  // DUT and checker
  //////////////////////////////////////////////////

  mul_unit_top UUT (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_bubble  (id_bubble),
    .id_instr   (id_instr),
    .op_a       (op_a),
    .op_b       (op_b),
    .st_xlen    (st_xlen),
    .mul_stall  (mul_stall),
    .mul_bubble (mul_bubble),
    .mul_r      (mul_r)
  );

  mul_checker u_checker (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_bubble  (id_bubble),
    .id_instr   (id_instr),
    .op_a       (op_a),
    .op_b       (op_b),
    .st_xlen    (st_xlen),
    .mul_stall  (mul_stall),
    .mul_bubble (mul_bubble),
    .mul_r      (mul_r),
    .drain_done (drain_done)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Corners first, then fully random words
  function automatic xword_t pick_operand();
    int k;
    k = {$random(seed)} % 10;
    case (k)
      0:       pick_operand = '0;
      1:       pick_operand = 64'd1;
      2:       pick_operand = '1;
      3:       pick_operand = 64'h8000_0000_0000_0000;
      4:       pick_operand = 64'h7fff_ffff_ffff_ffff;
      5:       pick_operand = 64'h0000_0000_8000_0000;
      6:       pick_operand = 64'h0000_0000_7fff_ffff;
      7:       pick_operand = 64'hffff_ffff_8000_0000;
      default: pick_operand = {$random(seed), $random(seed)};
    endcase
  endfunction

  // R-type word with random register fields
  function automatic instr_t make_word(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] opc);
    logic [31:0] r;
    r = $random(seed);
    make_word = {f7, r[24:20], r[19:15], f3, r[11:7], opc, QUAD_32};
  endfunction

  // One decode slot, held for as long as the unit stalls
  task automatic run_slot();
    int          kind;
    int          hold;
    int          i;
    logic [31:0] r;
    kind      = {$random(seed)} % 8;
    r         = $random(seed);
    st_xlen   = r[1:0];
    id_bubble = 1'b0;
    op_a      = pick_operand();
    op_b      = pick_operand();
    case (kind)
      0: id_instr = make_word(F7_MULDIV, F3_MUL, OPC_OP);
      1: id_instr = make_word(F7_MULDIV, F3_MULH, OPC_OP);
      2: id_instr = make_word(F7_MULDIV, F3_MULHSU, OPC_OP);
      3: id_instr = make_word(F7_MULDIV, F3_MULHU, OPC_OP);
      5: begin
        // Near misses of the multiply encodings
        case (r[3:2])
          2'b00: id_instr = make_word(7'b0000000, r[6:4], OPC_OP);
          2'b01: id_instr = make_word(F7_MULDIV, {1'b1, r[5:4]}, OPC_OP);
          2'b10: id_instr = make_word(F7_MULDIV, {r[5:4], 1'b1}, OPC_OP32);
          default: begin
            id_instr      = make_word(F7_MULDIV, F3_MUL, OPC_OP);
            id_instr[1:0] = 2'b01;
          end
        endcase
      end
      6: begin
        // Multiply word that decode marks as a bubble
        id_bubble = 1'b1;
        id_instr  = make_word(F7_MULDIV, {1'b0, r[5:4]}, OPC_OP);
      end
      default: id_instr = make_word(F7_MULDIV, F3_MUL, OPC_OP32);
    endcase
    hold = (r[9:8] == 2'b00) ? 1 + int'(r[10]) : 0;
    for (i = 0; i < hold; i++) begin
      ex_stall = 1'b1;
      @(negedge clk);
    end
    ex_stall = 1'b0;
    @(negedge clk);
    while (mul_stall) begin
      // Back-pressure in flight must not move the result slot
      r        = $random(seed);
      ex_stall = r[0];
      @(negedge clk);
    end
    ex_stall = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    seed       = 31;
    clk        = 1'b0;
    rstn       = 1'b0;
    ex_stall   = 1'b0;
    id_bubble  = 1'b1;
    id_instr   = '0;
    op_a       = '0;
    op_b       = '0;
    st_xlen    = 2'b10;
    drain_done = 1'b0;
    repeat (RST_CYCLES) @(negedge clk);
    rstn = 1'b1;
    for (n = 0; n < NUM_SLOTS; n++) begin
      run_slot();
    end
    // Bubbles until the last result has gone by
    id_bubble = 1'b1;
    repeat (MUL_LATENCY + 2) @(negedge clk);
    drain_done = 1'b1;
    repeat (2) @(negedge clk);
    errors = u_checker.value_errors + u_checker.proto_errors + u_checker.end_errors;
    $display("Errors: %0d value, %0d protocol, %0d end; %0d accepted, %0d results",
             u_checker.value_errors, u_checker.proto_errors, u_checker.end_errors,
             u_checker.acc_count, u_checker.res_count);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== all.f ====
verilog/rv_isa_pkg.sv
verilog/mul_cfg_pkg.sv
verilog/mul_decode.sv
verilog/mul_operand_prep.sv
verilog/mul_datapath.sv
verilog/mul_sequencer.sv
verilog/mul_unit_top.sv
tb/mul_checker.sv
tb/tb_mul_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_mul_unit \
  --Mdir obj_dir -o sim_tb_mul_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_mul_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the testbench output
if printf '%s\n' "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
